/* hdl/tlul_lite_pkg.sv */
package tlul_lite_pkg;

  // Bus address width in bits
  parameter int unsigned TL_AW  = 32;
  // Bus data width in bits
  parameter int unsigned TL_DW  = 32;
  // Bytes per bus word
  parameter int unsigned TL_DBW = TL_DW / 8;
  // Size field holds log2 of the transfer bytes
  parameter int unsigned TL_SZW = 2;

  // Byte address on the bus
  typedef logic [TL_AW-1:0]  tl_addr_t;
  // One full bus word
  typedef logic [TL_DW-1:0]  tl_data_t;
  // One enable bit per byte lane
  typedef logic [TL_DBW-1:0] tl_mask_t;
  // Transfer size as log2 of bytes
  typedef logic [TL_SZW-1:0] tl_size_t;

  // A-channel opcodes
  // Only full-word put and get are carried
  typedef enum logic [2:0] {
    PutFullData = 3'h0,
    Get         = 3'h4
  } tl_a_op_e;

  // D-channel opcodes
  // Data-carrying ack answers a Get
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Host to device bundle
  // A request fields plus the D-channel ready
  typedef struct packed {
    logic     a_valid;
    tl_a_op_e a_opcode;
    tl_size_t a_size;
    tl_addr_t a_address;
    tl_mask_t a_mask;
    tl_data_t a_data;
    logic     d_ready;
  } tl_h2d_t;

  // Device to host bundle
  // A-channel ready plus the response fields
  typedef struct packed {
    logic     a_ready;
    logic     d_valid;
    tl_d_op_e d_opcode;
    logic     d_error;
    tl_data_t d_data;
  } tl_d2h_t;

  // Idle values for a quiet bus
  parameter tl_h2d_t TL_H2D_IDLE = '{
    a_valid:   1'b0,
    a_opcode:  Get,
    a_size:    '0,
    a_address: '0,
    a_mask:    '0,
    a_data:    '0,
    d_ready:   1'b1
  };

endpackage

/* hdl/sram2tlul.sv */
`timescale 1ns/1ns

module sram2tlul
  import tlul_lite_pkg::*;
#(
  // Word address width on the SRAM side
  parameter int       SramAw     = 10,
  // Byte base OR'd into every request
  parameter tl_addr_t TlBaseAddr = 'h0
) (
  input  logic              clk_i,
  input  logic              arst_n_i,

  // SRAM-style request port
  input  logic              mem_req_i,
  input  logic              mem_write_i,
  input  logic [SramAw-1:0] mem_addr_i,
  input  tl_data_t          mem_wdata_i,
  output logic              mem_rvalid_o,
  output tl_data_t          mem_rdata_o,
  output logic [1:0]        mem_error_o,

  // TL-UL host side
  output tl_h2d_t           tl_o,
  input  tl_d2h_t           tl_i
);

  // Byte offset bits inside one word
  localparam int unsigned WordOffW = $clog2(TL_DBW);
  // Zero padding above the shifted word address
  localparam int unsigned PadW     = TL_AW - SramAw - WordOffW;

  // Request goes out in the same cycle as the strobe
  assign tl_o.a_valid   = mem_req_i;
  assign tl_o.a_opcode  = mem_write_i ? PutFullData : Get;
  // Always a full word
  assign tl_o.a_size    = tl_size_t'(WordOffW);
  // Word address to byte address, then place inside the window
  assign tl_o.a_address = TlBaseAddr |
                          {{PadW{1'b0}}, mem_addr_i, {WordOffW{1'b0}}};
  assign tl_o.a_mask    = '1;
  assign tl_o.a_data    = mem_wdata_i;
  // Responses are always taken
  assign tl_o.d_ready   = 1'b1;

  // Read data strobe for a data ack
  assign mem_rvalid_o = tl_i.d_valid && (tl_i.d_opcode == AccessAckData);
  assign mem_rdata_o  = tl_i.d_data;
  // Error on both bits, reads and writes alike
  assign mem_error_o  = {2{tl_i.d_valid && tl_i.d_error}};

endmodule

/* hdl/tlul_sram_device.sv */
`timescale 1ns/1ns

module tlul_sram_device
  import tlul_lite_pkg::*;
#(
  // Memory depth as a word address width
  parameter int       MemAw       = 8,
  // Byte base of the decode window
  parameter tl_addr_t DevBaseAddr = 'h0
) (
  input  logic    clk_i,
  input  logic    arst_n_i,

  // TL-UL device side
  input  tl_h2d_t tl_i,
  output tl_d2h_t tl_o
);

  // Number of words held
  localparam int unsigned Depth    = 2 ** MemAw;
  // Byte offset bits inside one word
  localparam int unsigned OffW     = $clog2(TL_DBW);
  // Window span in bytes
  localparam tl_addr_t    WinBytes = tl_addr_t'(TL_DBW) << MemAw;
  // Size code of a full-word transfer
  localparam tl_size_t    FullSize = tl_size_t'(OffW);

  // Decode
  tl_addr_t         addr_off;
  logic             win_hit;
  logic [MemAw-1:0] word_idx;
  logic             is_get;
  logic             is_put;

  // Storage
  tl_data_t         mem_q [Depth];
  tl_data_t         rd_word;
  tl_data_t         wr_word;
  logic             wr_en;

  // Registered response
  logic             d_valid_q;
  tl_d_op_e         d_opcode_q;
  logic             d_error_q;
  tl_data_t         d_data_q;

  // Offset from the base
  // below the base wraps to a large value and misses
  assign addr_off = tl_i.a_address - DevBaseAddr;

  // Inside the window and a full-word transfer
  assign win_hit  = (addr_off < WinBytes) && (tl_i.a_size == FullSize);

  // Word index inside the window
  assign word_idx = addr_off[OffW +: MemAw];

  assign is_get   = (tl_i.a_opcode == Get);
  assign is_put   = (tl_i.a_opcode == PutFullData);

  // Only puts that hit the window change memory
  assign wr_en    = tl_i.a_valid && is_put && win_hit;

  // Current word at the decoded index
  assign rd_word  = mem_q[word_idx];

  // Merge write data per byte lane
  // the converter always sends a full mask
  always_comb begin
    for (int unsigned b = 0; b < TL_DBW; b++) begin
      wr_word[8*b +: 8] = tl_i.a_mask[b] ? tl_i.a_data[8*b +: 8] : rd_word[8*b +: 8];
    end
  end

  // Word array, cleared by reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int unsigned i = 0; i < Depth; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en) begin
      mem_q[word_idx] <= wr_word;
    end
  end

  // Response control
  // every accepted request is answered the next cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      d_valid_q  <= 1'b0;
      d_opcode_q <= AccessAck;
      d_error_q  <= 1'b0;
    end else begin
      d_valid_q  <= tl_i.a_valid;
      d_opcode_q <= is_get ? AccessAckData : AccessAck;
      // Miss reported for both reads and writes
      d_error_q  <= tl_i.a_valid && !win_hit;
    end
  end

  // Response data
  // zero for writes and for misses
  always_ff @(posedge clk_i) begin
    if (tl_i.a_valid && is_get && win_hit) begin
      d_data_q <= rd_word;
    end else begin
      d_data_q <= '0;
    end
  end

  // No back-pressure on A
  assign tl_o.a_ready  = 1'b1;
  assign tl_o.d_valid  = d_valid_q;
  assign tl_o.d_opcode = d_opcode_q;
  assign tl_o.d_error  = d_error_q;
  assign tl_o.d_data   = d_data_q;

endmodule

/* hdl/sram_tlul_subsys_top.sv */
`timescale 1ns/1ns

module sram_tlul_subsys_top
  import tlul_lite_pkg::*;
#(
  // SRAM-side word address width
  parameter int       SramAw   = 10,
  // Device depth as a word address width
  parameter int       MemAw    = 8,
  // Byte base of the device window
  parameter tl_addr_t BaseAddr = 'h4000
) (
  input  logic              clk_i,
  input  logic              arst_n_i,

  // SRAM-style request port
  input  logic              mem_req_i,
  input  logic              mem_write_i,
  input  logic [SramAw-1:0] mem_addr_i,
  input  tl_data_t          mem_wdata_i,
  output logic              mem_rvalid_o,
  output tl_data_t          mem_rdata_o,
  output logic [1:0]        mem_error_o
);

  // Bus between converter and device
  tl_h2d_t tl_h2d;
  tl_d2h_t tl_d2h;

  // SRAM requests onto TL-UL
  sram2tlul #(
    .SramAw     (SramAw),
    .TlBaseAddr (BaseAddr)
  ) u_sram2tlul (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .mem_req_i    (mem_req_i),
    .mem_write_i  (mem_write_i),
    .mem_addr_i   (mem_addr_i),
    .mem_wdata_i  (mem_wdata_i),
    .mem_rvalid_o (mem_rvalid_o),
    .mem_rdata_o  (mem_rdata_o),
    .mem_error_o  (mem_error_o),
    .tl_o         (tl_h2d),
    .tl_i         (tl_d2h)
  );

  // Memory behind the bus
  // the window shares the converter's base
  tlul_sram_device #(
    .MemAw       (MemAw),
    .DevBaseAddr (BaseAddr)
  ) u_mem_dev (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .tl_i     (tl_h2d),
    .tl_o     (tl_d2h)
  );

endmodule

/* verification/sram_tlul_chk.sv */
`timescale 1ns/1ns

module sram_tlul_chk
  import tlul_lite_pkg::*;
(
  input logic    clk_i,
  input logic    arst_n_i,
  input tl_h2d_t tl_h2d_i,
  input tl_d2h_t tl_d2h_i,
  input logic    mem_rvalid_i
);

  // Count of assertion failures
  int unsigned fail_cnt = 0;

  // Device never stalls the converter
  a_ready_when_valid: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    tl_h2d_i.a_valid |-> tl_d2h_i.a_ready
  ) else begin
    $error("A channel request offered while a_ready is low");
    fail_cnt++;
  end

  // One response for every accepted request, one cycle later
  d_valid_next_cycle: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    tl_h2d_i.a_valid |=> tl_d2h_i.d_valid
  ) else begin
    $error("No D channel response one cycle after a request");
    fail_cnt++;
  end

  // Read data strobe only answers a Get from the cycle before
  rvalid_follows_get: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    mem_rvalid_i |-> $past(tl_h2d_i.a_valid && (tl_h2d_i.a_opcode == Get))
  ) else begin
    $error("mem_rvalid_o raised without a read in the previous cycle");
    fail_cnt++;
  end

endmodule

// Attach to every instance of the subsystem top
bind sram_tlul_subsys_top sram_tlul_chk u_chk (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .tl_h2d_i     (tl_h2d),
  .tl_d2h_i     (tl_d2h),
  .mem_rvalid_i (mem_rvalid_o)
);

/* verification/sram_tlul_tb.sv */
`timescale 1ns/1ns

module sram_tlul_tb
  import tlul_lite_pkg::*;
();

  localparam int       SramAw        = 10;
  localparam int       MemAw         = 8;
  localparam tl_addr_t BaseAddr      = 'h4000;
  localparam int       SramWords     = 2 ** SramAw;
  localparam int       MemWords      = 2 ** MemAw;
  // About 830 cycles of traffic, with margin
  localparam int       TimeoutCycles = 1500;
  localparam int       Seed          = 20101;

  // Expected outcome of one request
  typedef struct packed {
    logic     err;
    tl_data_t data;
  } exp_resp_t;

  // One queued expectation per driven cycle
  typedef struct packed {
    logic [31:0] cyc;
    logic        req;
    logic        wr;
    logic        err;
    tl_data_t    data;
  } exp_entry_t;

  logic              clk;
  logic              arst_n;
  logic              mem_req;
  logic              mem_write;
  logic [SramAw-1:0] mem_addr;
  tl_data_t          mem_wdata;
  logic              mem_rvalid;
  tl_data_t          mem_rdata;
  logic [1:0]        mem_error;

  // Reference model state
  tl_data_t          shadow [SramWords];
  exp_entry_t        exp_q [$];

  logic [31:0]       cyc = 0;
  string             cur_test = "none";
  int                test_errs = 0;
  int                total_errs = 0;
  int                tests_run = 0;
  int                tests_failed = 0;
  // Checker failures seen before the current test
  int unsigned       chk_base = 0;

  sram_tlul_subsys_top #(
    .SramAw   (SramAw),
    .MemAw    (MemAw),
    .BaseAddr (BaseAddr)
  ) uut (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .mem_req_i    (mem_req),
    .mem_write_i  (mem_write),
    .mem_addr_i   (mem_addr),
    .mem_wdata_i  (mem_wdata),
    .mem_rvalid_o (mem_rvalid),
    .mem_rdata_o  (mem_rdata),
    .mem_error_o  (mem_error)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Cycle count shared by the timeout and the response timing
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Words past the device depth miss; in-range writes update the shadow
  function automatic exp_resp_t exp_resp(input int unsigned addr, input logic is_write,
                                         input tl_data_t wdata);
    exp_resp_t r;
    r.err  = (addr >= MemWords);
    r.data = '0;
    if (!r.err) begin
      if (is_write) begin
        shadow[addr] = wdata;
      end else begin
        r.data = shadow[addr];
      end
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (act_v === exp_v) else begin
      $display("ERROR %s: %s expected 0x%08h actual 0x%08h (cycle %0d)",
               cur_test, what, exp_v, act_v, cyc);
      test_errs++;
    end
  endtask

  // Drive one cycle just after the edge and queue what should come back
  task automatic issue_req(input logic req, input logic wr, input int unsigned addr,
                           input tl_data_t wdata);
    exp_entry_t e;
    exp_resp_t  r;
    @(posedge clk);
    #1;
    mem_req   = req;
    mem_write = wr;
    mem_addr  = addr[SramAw-1:0];
    mem_wdata = wdata;
    r = '0;
    if (req) begin
      r = exp_resp(addr, wr, wdata);
    end
    e.cyc  = cyc;
    e.req  = req;
    e.wr   = wr;
    e.err  = r.err;
    e.data = r.data;
    exp_q.push_back(e);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) issue_req(1'b0, 1'b0, 0, '0);
  endtask

  // Reset for 8 cycles and clear the shadow like the device memory
  task automatic apply_reset();
    @(posedge clk);
    #1;
    arst_n  = 1'b0;
    mem_req = 1'b0;
    for (int i = 0; i < SramWords; i++) begin
      shadow[i] = '0;
    end
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
    chk_base  = uut.u_chk.fail_cnt;
  endtask

  // Let every queued response be compared, then report
  task automatic finish_test();
    idle_cycles(2);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
    // Bound assertions count against the test too
    test_errs += uut.u_chk.fail_cnt - chk_base;
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0) begin
      $display("test %s: pass", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: FAIL with %0d errors", cur_test, test_errs);
    end
  endtask

  // Compare at the falling edge where outputs are settled
  initial begin : compare_proc
    exp_entry_t e;
    forever begin
      @(negedge clk);
      if (!arst_n) begin
        check_value("mem_rvalid_o in reset", 32'd0, mem_rvalid);
        check_value("mem_error_o in reset", 32'd0, mem_error);
      end else if (exp_q.size() > 0 && exp_q[0].cyc < cyc) begin
        // Request from the previous cycle answers now
        e = exp_q.pop_front();
        check_value("mem_rvalid_o", e.req && !e.wr, mem_rvalid);
        check_value("mem_error_o", {2{e.req && e.err}}, mem_error);
        if (e.req && !e.wr) begin
          check_value("mem_rdata_o", e.data, mem_rdata);
        end
      end else begin
        // Nothing outstanding, bus must stay quiet
        check_value("mem_rvalid_o when idle", 32'd0, mem_rvalid);
        check_value("mem_error_o when idle", 32'd0, mem_error);
      end
    end
  end

  // Hang guard
  initial begin : timeout_watch
    wait (cyc >= TimeoutCycles);
    $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display("Test failed");
    $finish;
  end

  initial begin : main_seq
    int unsigned addr;
    logic        wr;
    tl_data_t    wdata;
    tl_data_t    keep_word;
    void'($urandom(Seed));
    arst_n    = 1'b0;
    mem_req   = 1'b0;
    mem_write = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;

    // Quiet outputs through reset, untouched words read zero
    begin_test("reset_idle");
    apply_reset();
    idle_cycles(3);
    issue_req(1'b1, 1'b0, 0, '0);
    issue_req(1'b1, 1'b0, MemWords / 2, '0);
    issue_req(1'b1, 1'b0, MemWords - 1, '0);
    finish_test();

    // Read straight after the write of the same word
    begin_test("write_then_read");
    issue_req(1'b1, 1'b1, 17, 32'hC0DE_5A17);
    issue_req(1'b1, 1'b0, 17, '0);
    finish_test();

    // One request per cycle; small range so reads hit written words
    begin_test("random_b2b");
    for (int i = 0; i < 400; i++) begin
      wr    = $urandom_range(0, 1);
      addr  = $urandom_range(0, 63);
      wdata = $urandom();
      issue_req(1'b1, wr, addr, wdata);
    end
    finish_test();

    // Misses including one whose low bits alias word 5
    begin_test("out_of_range");
    keep_word = $urandom();
    issue_req(1'b1, 1'b1, 5, keep_word);
    issue_req(1'b1, 1'b1, 5 + MemWords, ~keep_word);
    issue_req(1'b1, 1'b0, 5 + MemWords, '0);
    for (int i = 0; i < 40; i++) begin
      wr    = $urandom_range(0, 1);
      addr  = $urandom_range(MemWords, SramWords - 1);
      wdata = $urandom();
      issue_req(1'b1, wr, addr, wdata);
    end
    issue_req(1'b1, 1'b0, 5, '0);
    for (int i = 0; i < 8; i++) begin
      issue_req(1'b1, 1'b0, $urandom_range(0, MemWords - 1), '0);
    end
    finish_test();

    // Fresh memory, every fourth word written, full sweep read
    begin_test("addr_sweep");
    apply_reset();
    for (int i = 0; i < MemWords; i += 4) begin
      issue_req(1'b1, 1'b1, i, $urandom());
    end
    for (int i = 0; i < MemWords; i++) begin
      issue_req(1'b1, 1'b0, i, '0);
    end
    finish_test();

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, total_errs);
    if (tests_failed == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* all.f */
hdl/tlul_lite_pkg.sv
hdl/sram2tlul.sv
hdl/tlul_sram_device.sv
hdl/sram_tlul_subsys_top.sv
verification/sram_tlul_chk.sv
verification/sram_tlul_tb.sv
